//--- compile.f
hw/sq_pkg.sv
hw/store_queue.sv
hw/store_forward.sv
hw/lsq_store_top.sv
dv/sq_asserts.sv
dv/sq_tb.sv

//--- dv/sq_asserts.sv
`timescale 1ns/100ps

// protocol checks on the store queue
module sq_asserts import sq_pkg::*; (
	input logic      clock,
	input logic      reset,
	input logic      dispatch_en,
	input logic      rt_en,
	input logic      full,
	input logic      mem_wr_en,
	input sq_ptr_t   head,
	input sq_ptr_t   tail,
	input sq_entry_t entries [SQ_DEPTH]
);

	logic pop; // retire on a non-empty queue
	assign pop = rt_en && (head != tail);

	// full blocks the push so tail holds
	assert property (@(posedge clock) disable iff (reset)
		dispatch_en && full |=> tail == $past(tail))
		else $error("store accepted while the queue was full");

	assert property (@(posedge clock) disable iff (reset) pop |=> mem_wr_en)
		else $error("retire gave no memory write");

	assert property (@(posedge clock) disable iff (reset) !pop |=> !mem_wr_en)
		else $error("memory write without a retire");

	// head must be resolved before it leaves
	assert property (@(posedge clock) disable iff (reset)
		pop |-> entries[head.idx].addr_ready && entries[head.idx].data_ready)
		else $error("retired store had an unknown address or data");

	assert property (@(posedge clock) reset |=> !mem_wr_en)
		else $error("memory write strobe high after reset");

endmodule

bind store_queue sq_asserts sq_asserts_inst (
	.clock       (clock),
	.reset       (reset),
	.dispatch_en (dispatch_en),
	.rt_en       (rt_en),
	.full        (full),
	.mem_wr_en   (mem_wr_en),
	.head        (head),
	.tail        (tail),
	.entries     (entries)
);

//--- dv/sq_tb.sv
`timescale 1ns/100ps

// testbench for the store side of the load/store unit
// a reference queue in the testbench tracks every accepted store
module sq_tb import sq_pkg::*; ();

	logic         clock;
	logic         reset;
	logic         dispatch_en;
	sq_dispatch_t dispatch;
	logic         ex_en;
	sq_exec_t     ex;
	logic         rt_en;
	logic         rd_en;
	ld_req_t      ld_req;
	sq_idx_t      tail_out;
	logic         full;
	logic         mem_wr_en;
	mem_write_t   mem_wr;
	logic         rd_valid;
	ld_resp_t     ld_resp;

	// reference queue by physical slot
	logic [ADDR_W-1:0] m_addr [SQ_DEPTH];
	logic [DATA_W-1:0] m_data [SQ_DEPTH];
	logic              m_ar   [SQ_DEPTH];
	logic              m_dr   [SQ_DEPTH];
	int                pushed; // stores accepted so far with the tail pointer in the low 5 bits
	int                popped; // stores retired so far

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          tests;

	lsq_store_top lsq_store_top_inst (
		.clock       (clock),
		.reset       (reset),
		.dispatch_en (dispatch_en),
		.dispatch    (dispatch),
		.ex_en       (ex_en),
		.ex          (ex),
		.rt_en       (rt_en),
		.rd_en       (rd_en),
		.ld_req      (ld_req),
		.tail_out    (tail_out),
		.full        (full),
		.mem_wr_en   (mem_wr_en),
		.mem_wr      (mem_wr),
		.rd_valid    (rd_valid),
		.ld_resp     (ld_resp)
	);

	always #5 clock = ~clock; // 10 ns period

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic sq_dispatch_t make_store(input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic ar, input logic dr);
		sq_dispatch_t d;
		d.addr       = addr;
		d.data       = data;
		d.addr_ready = ar;
		d.data_ready = dr;
		return d;
	endfunction

	function automatic ld_resp_t make_resp(input sq_fwd_e s, input logic [DATA_W-1:0] d);
		ld_resp_t r;
		r.status = s;
		r.data   = d;
		return r;
	endfunction

	// fully resolved store at a random doubleword
	task automatic rand_store(output sq_dispatch_t d);
		logic [63:0] a;
		logic [63:0] v;
		take_bits(29, a);
		take_bits(64, v);
		d = make_store({a[28:0], 3'b000}, v, 1'b1, 1'b1);
	endtask

	// expected answer walks youngest older store first back to the oldest live one
	function automatic ld_resp_t expect_fwd(input logic [ADDR_W-1:0] addr, input int ld_cnt);
		ld_resp_t r;
		int       youngest;
		int       slot;
		logic     done;
		r        = make_resp(FWD_MISS, '0);
		done     = 1'b0;
		youngest = (ld_cnt < pushed) ? ld_cnt : pushed; // nothing beyond the tail exists
		for (int c = youngest - 1; c >= popped && !done; c--) begin
			slot = c % SQ_DEPTH;
			if (!m_ar[slot]) begin
				r    = make_resp(FWD_WAIT, '0); // could alias anything
				done = 1'b1;
			end else if (m_addr[slot][ADDR_W-1:3] == addr[ADDR_W-1:3]) begin
				r    = m_dr[slot] ? make_resp(FWD_HIT, m_data[slot]) : make_resp(FWD_WAIT, '0);
				done = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input sq_idx_t got, input sq_idx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_write(input string name, input mem_write_t got, input mem_write_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h/%h expected %h/%h", $time, name,
				got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	// a wait answer carries no defined data
	task automatic check_resp(input string name, input ld_resp_t got, input ld_resp_t exp);
		checks++;
		if (got.status !== exp.status || (exp.status != FWD_WAIT && got.data !== exp.data)) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d/%h expected %0d/%h", $time, name,
				got.status, got.data, exp.status, exp.data);
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1; // inputs move just after the edge
	endtask

	// one clock of dispatch and/or retire checked against the reference queue
	task automatic queue_cycle(input logic do_disp, input sq_dispatch_t d, input logic do_rt);
		mem_write_t exp_wr;
		sq_idx_t    hslot;
		sq_idx_t    tslot;
		logic       pop_ok;
		logic       push_ok;
		int         occ;
		occ     = pushed - popped;
		hslot   = popped[SQ_IDX_W-1:0];
		tslot   = pushed[SQ_IDX_W-1:0];
		pop_ok  = do_rt && occ > 0;
		push_ok = do_disp && (occ < SQ_DEPTH || pop_ok); // retire frees a slot
		exp_wr.addr = m_addr[hslot];
		exp_wr.data = m_data[hslot];
		dispatch_en = do_disp;
		dispatch    = d;
		rt_en       = do_rt;
		#1;
		check_bit("full", full, occ == SQ_DEPTH && !pop_ok);
		if (do_disp)
			check_idx("tail_out", tail_out, tslot);
		next_cycle();
		dispatch_en = 1'b0;
		rt_en       = 1'b0;
		check_bit("mem_wr_en", mem_wr_en, pop_ok); // commit lands one cycle after retire
		if (pop_ok) begin
			check_write("mem_wr", mem_wr, exp_wr);
			popped++;
		end
		if (push_ok) begin
			m_addr[tslot] = d.addr;
			m_data[tslot] = d.data;
			m_ar[tslot]   = d.addr_ready;
			m_dr[tslot]   = d.data_ready;
			pushed++;
		end
	endtask

	task automatic drain();
		while (pushed > popped)
			queue_cycle(1'b0, '0, 1'b1);
	endtask

	task automatic execute_store(input sq_idx_t slot, input logic addr_en,
			input logic [ADDR_W-1:0] addr, input logic data_en, input logic [DATA_W-1:0] data);
		ex_en      = 1'b1;
		ex.index   = slot;
		ex.addr    = addr;
		ex.addr_en = addr_en;
		ex.data    = data;
		ex.data_en = data_en;
		next_cycle();
		ex_en = 1'b0;
		if (addr_en) begin
			m_addr[slot] = addr;
			m_ar[slot]   = 1'b1;
		end
		if (data_en) begin
			m_data[slot] = data;
			m_dr[slot]   = 1'b1;
		end
	endtask

	// search is combinational so the answer is sampled mid cycle
	task automatic lookup_expect(input logic [ADDR_W-1:0] addr, input int ld_cnt,
			input ld_resp_t exp);
		rd_en         = 1'b1;
		ld_req.addr   = addr;
		ld_req.ld_pos = ld_cnt[SQ_IDX_W:0];
		#4;
		check_bit("rd_valid", rd_valid, 1'b1);
		check_resp("ld_resp", ld_resp, exp);
		next_cycle();
		rd_en = 1'b0;
	endtask

	task automatic lookup(input logic [ADDR_W-1:0] addr, input int ld_cnt);
		lookup_expect(addr, ld_cnt, expect_fwd(addr, ld_cnt));
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("%-20s pass", name);
		else
			$display("%-20s FAIL, %0d failed checks", name, errors - err_before);
	endtask

	task automatic test_reset_state();
		int          err0;
		logic [63:0] a;
		err0 = errors;
		take_bits(32, a);
		check_bit("full", full, 1'b0);
		check_bit("mem_wr_en", mem_wr_en, 1'b0);
		check_bit("rd_valid", rd_valid, 1'b0); // no lookup asked yet
		check_idx("tail_out", tail_out, 4'd0);
		lookup_expect(a[31:0], 0, make_resp(FWD_MISS, '0));
		lookup_expect(a[31:0], 9, make_resp(FWD_MISS, '0));  // no valid slot anywhere
		lookup_expect(a[31:0], 16, make_resp(FWD_MISS, '0));
		finish_test("reset_state", err0);
	endtask

	task automatic test_fill_and_full();
		int           err0;
		sq_dispatch_t d;
		err0 = errors;
		for (int i = 0; i <= SQ_DEPTH; i++) begin
			rand_store(d);
			queue_cycle(1'b1, d, 1'b0); // last one meets a full queue and is dropped
		end
		check_bit("full", full, 1'b1);
		drain();
		queue_cycle(1'b0, '0, 1'b1); // empty retire gives no commit
		check_bit("full", full, 1'b0);
		finish_test("fill_and_full", err0);
	endtask

	task automatic test_retire_order();
		int           err0;
		sq_dispatch_t d;
		err0 = errors;
		repeat (6) begin
			rand_store(d);
			queue_cycle(1'b1, d, 1'b0);
		end
		repeat (4)
			queue_cycle(1'b0, '0, 1'b1);
		while (pushed - popped < SQ_DEPTH) begin
			rand_store(d);
			queue_cycle(1'b1, d, 1'b0);
		end
		rand_store(d);
		queue_cycle(1'b1, d, 1'b1); // queue full but the pop makes room
		drain();                    // pointers wrap on the way out
		finish_test("retire_order", err0);
	endtask

	task automatic test_forwarding();
		int                err0;
		int                base;
		logic [63:0]       v;
		logic [ADDR_W-1:0] store_addr [5];
		logic [ADDR_W-1:0] probe [4];
		err0       = errors;
		store_addr = '{32'h0000_1000, 32'h0000_2008, 32'h0000_1004, 32'h0000_2008, 32'h0000_1000};
		probe      = '{32'h0000_1000, 32'h0000_2008, 32'h0000_1007, 32'h0000_3000};
		base       = popped;
		for (int i = 0; i < 5; i++) begin
			take_bits(64, v);
			queue_cycle(1'b1, make_store(store_addr[i], v, 1'b1, 1'b1), 1'b0);
		end
		for (int p = base; p <= pushed; p++)
			for (int a = 0; a < 4; a++)
				lookup(probe[a], p);
		repeat (2)
			queue_cycle(1'b0, '0, 1'b1);
		// retired stores drop out of every answer
		for (int p = base; p <= pushed; p++)
			for (int a = 0; a < 4; a++)
				lookup(probe[a], p);
		drain();
		finish_test("forwarding", err0);
	endtask

	task automatic test_wait_and_execute();
		int          err0;
		sq_idx_t     slot;
		logic [63:0] v;
		logic [63:0] late;
		err0 = errors;
		take_bits(64, v);
		queue_cycle(1'b1, make_store(32'h0000_4000, v, 1'b1, 1'b1), 1'b0);
		// unknown address in front of the load
		take_bits(64, late);
		slot = pushed[SQ_IDX_W-1:0];
		queue_cycle(1'b1, make_store('0, late, 1'b0, 1'b1), 1'b0);
		lookup_expect(32'h0000_4000, pushed, make_resp(FWD_WAIT, '0));
		execute_store(slot, 1'b1, 32'h0000_4000, 1'b0, '0);
		lookup_expect(32'h0000_4000, pushed, make_resp(FWD_HIT, late));
		// known address, data still pending
		slot = pushed[SQ_IDX_W-1:0];
		queue_cycle(1'b1, make_store(32'h0000_5000, '0, 1'b1, 1'b0), 1'b0);
		lookup_expect(32'h0000_5000, pushed, make_resp(FWD_WAIT, '0));
		take_bits(64, late);
		execute_store(slot, 1'b0, '0, 1'b1, late);
		lookup_expect(32'h0000_5000, pushed, make_resp(FWD_HIT, late));
		// address resolves somewhere else
		take_bits(64, late);
		slot = pushed[SQ_IDX_W-1:0];
		queue_cycle(1'b1, make_store('0, late, 1'b0, 1'b1), 1'b0);
		lookup_expect(32'h0000_6000, pushed, make_resp(FWD_WAIT, '0));
		execute_store(slot, 1'b1, 32'h0000_7000, 1'b0, '0);
		lookup_expect(32'h0000_6000, pushed, make_resp(FWD_MISS, '0));
		lookup_expect(32'h0000_7000, pushed, make_resp(FWD_HIT, late));
		drain();
		finish_test("wait_and_execute", err0);
	endtask

	initial begin
		clock       = 1'b0;
		reset       = 1'b1;
		dispatch_en = 1'b0;
		dispatch    = '0;
		ex_en       = 1'b0;
		ex          = '0;
		rt_en       = 1'b0;
		rd_en       = 1'b0;
		ld_req      = '0;
		lfsr        = 32'h6739;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		pushed      = 0;
		popped      = 0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_fill_and_full();
		test_retire_order();
		test_forwarding();
		test_wait_and_execute();
		$display("tests %0d, checks %0d, failed checks %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog from the cycles per test in run order plus a margin
	initial begin
		int cycles;
		cycles = 5 + 3 + 34 + 41 + 58 + 18;
		#(cycles * 10 + 500);
		$display("timeout: tests still running after %0d ns", cycles * 10 + 500);
		$display("Errors found");
		$finish;
	end

endmodule

//--- hw/lsq_store_top.sv
`timescale 1ns/100ps

// store half of the load/store unit
// queue storage plus the forwarding search that reads it
module lsq_store_top import sq_pkg::*; (
	input  logic         clock,
	input  logic         reset,

	input  logic         dispatch_en,
	input  sq_dispatch_t dispatch,

	input  logic         ex_en,
	input  sq_exec_t     ex,

	input  logic         rt_en,

	input  logic         rd_en,
	input  ld_req_t      ld_req,

	output sq_idx_t      tail_out,
	output logic         full,
	output logic         mem_wr_en,
	output mem_write_t   mem_wr,
	output logic         rd_valid,
	output ld_resp_t     ld_resp
);

	// registered queue state shared with the search
	sq_entry_t           entries [SQ_DEPTH];
	logic [SQ_DEPTH-1:0] valid;
	sq_ptr_t             head;

	store_queue store_queue_inst (
		.clock       (clock),
		.reset       (reset),
		.dispatch_en (dispatch_en),
		.dispatch    (dispatch),
		.ex_en       (ex_en),
		.ex          (ex),
		.rt_en       (rt_en),
		.tail_out    (tail_out),
		.full        (full),
		.mem_wr_en   (mem_wr_en),
		.mem_wr      (mem_wr),
		.entries     (entries),
		.valid       (valid),
		.head        (head)
	);

	// sees only what the queue has registered
	store_forward store_forward_inst (
		.rd_en    (rd_en),
		.ld_req   (ld_req),
		.entries  (entries),
		.valid    (valid),
		.head     (head),
		.rd_valid (rd_valid),
		.ld_resp  (ld_resp)
	);

endmodule

//--- hw/sq_pkg.sv
package sq_pkg;

	// queue geometry
	localparam int SQ_DEPTH = 16;           // store queue entries
	localparam int SQ_IDX_W = 4;            // bits to index one entry
	localparam int SQ_PTR_W = SQ_IDX_W + 1; // index plus wrap bit

	// datapath widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int DW_LSB = 3;              // doubleword offset bits ignored on compare

	typedef logic [SQ_IDX_W-1:0] sq_idx_t;

	// head/tail pointer, wrap bit flips on every pass around the ring
	typedef struct packed {
		logic    wrap;
		sq_idx_t idx;
	} sq_ptr_t;

	// store as it leaves dispatch
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              addr_ready; // address already known
		logic              data_ready; // data already known
	} sq_dispatch_t;

	// late address or data from the execute stage
	typedef struct packed {
		sq_idx_t           index;   // queue slot given at dispatch
		logic [ADDR_W-1:0] addr;
		logic              addr_en; // write addr into the slot
		logic [DATA_W-1:0] data;
		logic              data_en; // write data into the slot
	} sq_exec_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              addr_ready;
		logic [DATA_W-1:0] data;
		logic              data_ready;
	} sq_entry_t;

	// load lookup
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		sq_ptr_t           ld_pos; // store tail seen when the load dispatched
	} ld_req_t;

	typedef enum logic [1:0] {
		FWD_MISS = 2'd0, // no older store to this doubleword
		FWD_HIT  = 2'd1, // youngest older store supplies the data
		FWD_WAIT = 2'd2  // an older store is still unresolved
	} sq_fwd_e;

	typedef struct packed {
		sq_fwd_e           status;
		logic [DATA_W-1:0] data;
	} ld_resp_t;

	// one doubleword write toward memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_write_t;

endpackage

//--- hw/store_forward.sv
`timescale 1ns/100ps

// store to load forwarding
// pure combinational search over the registered queue contents
module store_forward import sq_pkg::*; (
	input  logic                rd_en,   // load asks for forwarding
	input  ld_req_t             ld_req,

	// queue state from store_queue
	input  sq_entry_t           entries [SQ_DEPTH],
	input  logic [SQ_DEPTH-1:0] valid,
	input  sq_ptr_t             head,

	output logic                rd_valid,
	output ld_resp_t            ld_resp
);

	logic [SQ_PTR_W-1:0]     span_raw; // ld_pos minus head, mod 2*depth
	logic [SQ_PTR_W-1:0]     span;     // number of stores older than the load
	logic [SQ_DEPTH-1:0]     older;    // per physical slot, older than the load
	logic [ADDR_W-1:DW_LSB]  ld_dw;    // doubleword address of the load

	assign rd_valid = rd_en; // answer is always same-cycle

	assign ld_dw = ld_req.addr[ADDR_W-1:DW_LSB];

	// distance from head up to the load's tail snapshot
	assign span_raw = ld_ljust(ld_req.ld_pos) - ld_ljust(head);

	// head already past ld_pos means every older store has retired
	assign span = (span_raw > SQ_PTR_W'(SQ_DEPTH)) ? '0 : span_raw;

	// age mask, slot i is older if its distance from head is inside span
	always_comb begin
		sq_idx_t offset;
		offset = '0;
		for (int i = 0; i < SQ_DEPTH; i++) begin
			offset   = sq_idx_t'(i) - head.idx;
			older[i] = valid[i] && ({1'b0, offset} < span);
		end
	end

	// walk oldest to youngest and let every stopping entry overwrite
	// so the youngest stopping entry decides, same as a youngest-first scan
	always_comb begin
		sq_idx_t slot;
		slot           = '0;
		ld_resp.status = FWD_MISS;
		ld_resp.data   = '0;
		if (rd_en) begin
			for (int k = 0; k < SQ_DEPTH; k++) begin
				slot = head.idx + sq_idx_t'(k);
				if (older[slot]) begin
					if (!entries[slot].addr_ready) begin
						// unknown address might alias the load
						ld_resp.status = FWD_WAIT;
						ld_resp.data   = '0;
					end else if (entries[slot].addr[ADDR_W-1:DW_LSB] == ld_dw) begin
						if (entries[slot].data_ready) begin
							ld_resp.status = FWD_HIT;
							ld_resp.data   = entries[slot].data;
						end else begin
							ld_resp.status = FWD_WAIT; // match but data pending
							ld_resp.data   = '0;
						end
					end
				end
			end
		end
	end

	// pointer as a plain vector for the distance math
	function automatic logic [SQ_PTR_W-1:0] ld_ljust(input sq_ptr_t p);
		return {p.wrap, p.idx};
	endfunction

endmodule

//--- hw/store_queue.sv
`timescale 1ns/100ps

// circular store queue
// stores enter at tail in program order and leave at head on retire
module store_queue import sq_pkg::*; (
	input  logic                clock,
	input  logic                reset,

	// dispatch side
	input  logic                dispatch_en, // a store is being dispatched
	input  sq_dispatch_t        dispatch,

	// execute side
	input  logic                ex_en,       // execute fills in a field by index
	input  sq_exec_t            ex,

	// retire side
	input  logic                rt_en,       // oldest store is retiring

	output sq_idx_t             tail_out,    // slot for the store dispatched this cycle
	output logic                full,

	// commit toward memory, one cycle after retire
	output logic                mem_wr_en,
	output mem_write_t          mem_wr,

	// raw queue state for the forwarding search
	output sq_entry_t           entries [SQ_DEPTH],
	output logic [SQ_DEPTH-1:0] valid,
	output sq_ptr_t             head
);

	sq_ptr_t   tail;       // next free slot with wrap bit
	sq_ptr_t   head_inc;   // head after one pop
	sq_ptr_t   tail_inc;   // tail after one push
	sq_entry_t head_entry; // oldest entry, source of the commit

	logic empty;    // pointers identical
	logic ptr_full; // same index but opposite wrap
	logic rt_fire;  // retire actually pops
	logic dp_fire;  // dispatch actually pushes

	// occupancy from the pointers
	assign empty    = (head == tail);
	assign ptr_full = (head.idx == tail.idx) && (head.wrap != tail.wrap);

	// retire on an empty queue is a no-op
	assign rt_fire = rt_en && !empty;

	// a pop this cycle frees the slot the push needs
	assign full    = ptr_full && !rt_fire;
	assign dp_fire = dispatch_en && !full;

	// ring increments, wrap bit toggles when idx rolls over
	assign head_inc = sq_ptr_t'(head + SQ_PTR_W'(1));
	assign tail_inc = sq_ptr_t'(tail + SQ_PTR_W'(1));

	assign tail_out   = tail.idx;
	assign head_entry = entries[head.idx];

	// pointers, valid mask and commit strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			head      <= '0;
			tail      <= '0;
			valid     <= '0;
			mem_wr_en <= 1'b0;
		end else begin
			if (rt_fire) begin
				head <= head_inc;
			end
			if (dp_fire) begin
				tail <= tail_inc;
			end

			// clear before set so a full-queue retire plus dispatch
			// leaves the reused slot valid
			if (rt_fire) begin
				valid[head.idx] <= 1'b0;
			end
			if (dp_fire) begin
				valid[tail.idx] <= 1'b1;
			end

			mem_wr_en <= rt_fire; // one-cycle pulse per popped entry
		end
	end

	// entry storage
	always_ff @(posedge clock) begin
		// new store lands at tail
		if (dp_fire) begin
			entries[tail.idx].addr       <= dispatch.addr;
			entries[tail.idx].addr_ready <= dispatch.addr_ready;
			entries[tail.idx].data       <= dispatch.data;
			entries[tail.idx].data_ready <= dispatch.data_ready;
		end

		// execute resolves whichever fields it carries
		if (ex_en) begin
			if (ex.addr_en) begin
				entries[ex.index].addr       <= ex.addr;
				entries[ex.index].addr_ready <= 1'b1;
			end
			if (ex.data_en) begin
				entries[ex.index].data       <= ex.data;
				entries[ex.index].data_ready <= 1'b1;
			end
		end
	end

	// registered memory write
	// payload only changes when a pop happens, strobe qualifies it
	always_ff @(posedge clock) begin
		if (rt_fire) begin
			mem_wr.addr <= head_entry.addr;
			mem_wr.data <= head_entry.data;
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the store queue testbench with Verilator, run it, then judge the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

# assertions on, timing kept for the testbench delays
if ! verilator --binary --timing --assert \
	--top-module sq_tb \
	-Mdir "$build_dir" \
	-f compile.f; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vsq_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

# a failed assertion stops the run with a nonzero status
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Errors found" "$log_file"; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "No errors" "$log_file"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
exit 0
